/* design/mem_req_if.sv */
interface mem_req_if (
    input logic clk,
    input logic rst_n
);

    // Request held by the decode stage.
    logic                          valid;
    logic                          uncache;
    logic                          we;
    logic [mmio_pkg::addr_w-1:0]   addr;
    logic [mmio_pkg::addr_w-1:0]   bus_addr;
    logic [2:0]                    size;
    logic [mmio_pkg::data_w-1:0]   data;
    logic [mmio_pkg::mask_w-1:0]   mask;

    // Selected downstream port finished, back from the issue stage.
    logic                          done;

    modport producer (
        input  done,
        output valid, uncache, we, addr, bus_addr, size, data, mask
    );

    // Issue stage has no clock port of its own.
    // It borrows clk and rst_n here for its checks.
    modport consumer (
        input  clk, rst_n,
        input  valid, uncache, we, addr, bus_addr, size, data, mask,
        output done
    );

endinterface

/* design/mmio_pkg.sv */
package mmio_pkg;

    // Data path widths.
    localparam int addr_w = 64;
    localparam int data_w = 64;
    localparam int mask_w = 8;

    // UART register window.
    localparam logic [addr_w-1:0] uart_start    = 64'h0000_0000_1000_0000;
    localparam logic [addr_w-1:0] uart_end      = 64'h0000_0000_1000_0FFF;

    // SPI controller registers.
    localparam logic [addr_w-1:0] spictrl_start = 64'h0000_0000_1000_1000;
    localparam logic [addr_w-1:0] spictrl_end   = 64'h0000_0000_1000_1FFF;

    // SPI flash, mapped through the controller.
    localparam logic [addr_w-1:0] spi_start     = 64'h0000_0000_3000_0000;
    localparam logic [addr_w-1:0] spi_end       = 64'h0000_0000_3FFF_FFFF;

    // Core-local interruptor, timer and software interrupt.
    localparam logic [addr_w-1:0] clint_start   = 64'h0000_0000_0200_0000;
    localparam logic [addr_w-1:0] clint_end     = 64'h0000_0000_0200_FFFF;

    // Access types from the load/store unit.
    // Unlisted codes fall back to byte.
    localparam logic [2:0] type_byte  = 3'd0;
    localparam logic [2:0] type_half  = 3'd1;
    localparam logic [2:0] type_word  = 3'd2;
    localparam logic [2:0] type_dword = 3'd4;

    // Bus transfer size, log2 of the byte count.
    localparam logic [2:0] size_1 = 3'd0;
    localparam logic [2:0] size_2 = 3'd1;
    localparam logic [2:0] size_4 = 3'd2;
    localparam logic [2:0] size_8 = 3'd3;

    // Region flag reported on mmio_sign.
    localparam logic [2:0] sign_clint = 3'b010;
    localparam logic [2:0] sign_other = 3'b100;

    // Decode stage FSM states.
    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_busy  = 2'd1;
    localparam logic [1:0] st_drain = 2'd2;

endpackage

/* design/path_issue.sv */
module path_issue (
    mem_req_if.consumer                   req,

    output logic [mmio_pkg::addr_w-1:0]   dcache_addr,
    output logic [mmio_pkg::data_w-1:0]   dcache_data,
    output logic [mmio_pkg::mask_w-1:0]   dcache_mask,
    output logic                          dcache_we,
    output logic                          dcache_re,
    input  logic [mmio_pkg::data_w-1:0]   in_dcache_data,
    input  logic                          in_dcache_finish,

    output logic [mmio_pkg::addr_w-1:0]   arb_addr,
    output logic [mmio_pkg::data_w-1:0]   arb_data,
    output logic [mmio_pkg::mask_w-1:0]   arb_mask,
    output logic                          arb_we,
    output logic                          arb_re,
    output logic [2:0]                    arb_size_data,
    input  logic [mmio_pkg::data_w-1:0]   in_arb_data,
    input  logic                          in_arb_finish,

    output logic                          path_finish,
    output logic [mmio_pkg::data_w-1:0]   path_data,
    output logic                          path_uncache,
    output logic                          path_we
);

    logic sel_dc;
    logic sel_arb;
    logic dc_act;
    logic arb_act;

    // Port choice for the held request.
    assign sel_dc  = req.valid && !req.uncache;
    assign sel_arb = req.valid && req.uncache;

    // Only the selected port may end the access.
    // A stray finish on the other port is dropped.
    assign req.done = (sel_dc && in_dcache_finish) || (sel_arb && in_arb_finish);

    // Strobes fall in the finish cycle itself.
    assign dc_act  = sel_dc && !in_dcache_finish;
    assign arb_act = sel_arb && !in_arb_finish;

    // Cache side gets the raw address.
    assign dcache_re   = dc_act && !req.we;
    assign dcache_we   = dc_act && req.we;
    assign dcache_addr = dc_act ? req.addr : '0;
    assign dcache_data = dc_act ? req.data : '0;
    assign dcache_mask = dc_act ? req.mask : '0;

    // Device side gets the aligned address and a size.
    assign arb_re        = arb_act && !req.we;
    assign arb_we        = arb_act && req.we;
    assign arb_addr      = arb_act ? req.bus_addr : '0;
    assign arb_mask      = arb_act ? req.mask : '0;
    assign arb_size_data = arb_act ? req.size : '0;

    // Write data only.
    assign arb_data = (arb_act && req.we) ? req.data : '0;

    // Completion toward the merge stage.
    assign path_finish  = req.done;
    assign path_uncache = req.uncache;
    assign path_we      = req.we;
    assign path_data    = req.uncache ? in_arb_data : in_dcache_data;

    // One downstream port per access.
    a_one_port: assert property (
        @(posedge req.clk) disable iff (!req.rst_n)
        !((dcache_re || dcache_we) && (arb_re || arb_we))
    );

    // Device bus never sees both directions.
    a_arb_dir: assert property (
        @(posedge req.clk) disable iff (!req.rst_n)
        !(arb_re && arb_we)
    );

endmodule

/* design/req_decode.sv */
module req_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mmio_pkg::addr_w-1:0]   core_addr,
    input  logic [mmio_pkg::data_w-1:0]   core_data,
    input  logic [mmio_pkg::mask_w-1:0]   core_mask,
    input  logic [2:0]                    core_we_type,
    input  logic                          core_we,
    input  logic [2:0]                    core_re_type,
    input  logic                          core_re,
    output logic [2:0]                    mmio_sign,
    mem_req_if.producer                   req
);

    logic [1:0]                    state;
    logic                          start;
    logic                          capture;
    logic                          in_uart;
    logic                          in_spictrl;
    logic                          in_spi;
    logic                          in_clint;
    logic                          is_uncache;
    logic [2:0]                    op_type;
    logic [2:0]                    op_size;
    logic [mmio_pkg::addr_w-1:0]   op_bus_addr;

    // Access type to bus size.
    function automatic logic [2:0] type_to_size(input logic [2:0] op);
        case (op)
            mmio_pkg::type_half:  return mmio_pkg::size_2;
            mmio_pkg::type_word:  return mmio_pkg::size_4;
            mmio_pkg::type_dword: return mmio_pkg::size_8;
            default:              return mmio_pkg::size_1;
        endcase
    endfunction

    // Core holds either strobe as a level.
    assign start   = core_we | core_re;
    assign capture = (state == mmio_pkg::st_idle) && start;

    // Device windows, all inclusive.
    assign in_uart    = (core_addr >= mmio_pkg::uart_start) &&
                        (core_addr <= mmio_pkg::uart_end);
    assign in_spictrl = (core_addr >= mmio_pkg::spictrl_start) &&
                        (core_addr <= mmio_pkg::spictrl_end);
    assign in_spi     = (core_addr >= mmio_pkg::spi_start) &&
                        (core_addr <= mmio_pkg::spi_end);
    assign in_clint   = (core_addr >= mmio_pkg::clint_start) &&
                        (core_addr <= mmio_pkg::clint_end);

    // Anything outside the device windows is cacheable.
    assign is_uncache = in_uart | in_spictrl | in_spi | in_clint;

    // Size comes from the type of the active operation.
    assign op_type = core_we ? core_we_type : core_re_type;
    assign op_size = type_to_size(op_type);

    // Clear the low address bits down to the transfer size.
    always_comb begin
        case (op_size)
            mmio_pkg::size_2: op_bus_addr = {core_addr[mmio_pkg::addr_w-1:1], 1'b0};
            mmio_pkg::size_4: op_bus_addr = {core_addr[mmio_pkg::addr_w-1:2], 2'b00};
            mmio_pkg::size_8: op_bus_addr = {core_addr[mmio_pkg::addr_w-1:3], 3'b000};
            default:          op_bus_addr = core_addr;
        endcase
    end

    // Idle, busy until done, then one drain cycle.
    // Drain covers the finish pulse so a held request is not taken twice.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= mmio_pkg::st_idle;
            req.valid <= 1'b0;
            mmio_sign <= mmio_pkg::sign_other;
        end else begin
            case (state)
                mmio_pkg::st_idle: begin
                    if (start) begin
                        state     <= mmio_pkg::st_busy;
                        req.valid <= 1'b1;
                        mmio_sign <= in_clint ? mmio_pkg::sign_clint : mmio_pkg::sign_other;
                    end
                end
                mmio_pkg::st_busy: begin
                    if (req.done) begin
                        state     <= mmio_pkg::st_drain;
                        req.valid <= 1'b0;
                    end
                end
                mmio_pkg::st_drain: begin
                    state     <= mmio_pkg::st_idle;
                    mmio_sign <= mmio_pkg::sign_other;
                end
                default: begin
                    state     <= mmio_pkg::st_idle;
                    req.valid <= 1'b0;
                end
            endcase
        end
    end

    // Request payload, loaded on capture only.
    always_ff @(posedge clk) begin
        if (capture) begin
            req.uncache  <= is_uncache;
            req.we       <= core_we;
            req.addr     <= core_addr;
            req.bus_addr <= op_bus_addr;
            req.size     <= op_size;
            req.data     <= core_data;
            req.mask     <= core_mask;
        end
    end

    // No new request goes out while the finish is still in flight.
    a_no_issue_in_drain: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == mmio_pkg::st_drain) |=> !$rose(req.valid)
    );

    // Core presents one direction at a time.
    a_one_direction: assert property (
        @(posedge clk) disable iff (!rst_n)
        capture |-> !(core_we && core_re)
    );

endmodule

/* design/resp_merge.sv */
module resp_merge (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          path_finish,
    input  logic [mmio_pkg::data_w-1:0]   path_data,
    input  logic                          path_uncache,
    input  logic                          path_we,
    output logic [mmio_pkg::data_w-1:0]   in_core_data,
    output logic                          in_core_finish
);

    logic load_data;

    // Reads update the data word, writes keep the last one.
    assign load_data = path_finish && !path_we;

    // Finish is a single-cycle level from the issue stage.
    // One register stage turns it into the core pulse.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_core_finish <= 1'b0;
        end else begin
            in_core_finish <= path_finish;
        end
    end

    // Data stays put between finishes.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            in_core_data <= '0;
        end else if (load_data) begin
            in_core_data <= path_data;
        end
    end

    // Decode drains for a cycle, so finishes never come back to back.
    a_finish_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        in_core_finish |=> !in_core_finish
    );

    // A completing read brings defined data from a defined source.
    a_read_data_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_data |-> !$isunknown({path_uncache, path_data})
    );

endmodule

/* design/uncache_mmio.sv */
module uncache_mmio (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [2:0]                    mmio_sign,

    input  logic [mmio_pkg::addr_w-1:0]   core_addr,
    input  logic [mmio_pkg::data_w-1:0]   core_data,
    input  logic [mmio_pkg::mask_w-1:0]   core_mask,
    input  logic                          fence_in,
    input  logic [2:0]                    core_we_type,
    input  logic                          core_we,
    input  logic [2:0]                    core_re_type,
    input  logic                          core_re,
    output logic [mmio_pkg::data_w-1:0]   in_core_data,
    output logic                          in_core_finish,

    output logic [mmio_pkg::addr_w-1:0]   arb_addr,
    output logic [mmio_pkg::data_w-1:0]   arb_data,
    output logic [mmio_pkg::mask_w-1:0]   arb_mask,
    output logic                          arb_we,
    output logic                          arb_re,
    output logic [2:0]                    arb_size_data,
    input  logic [mmio_pkg::data_w-1:0]   in_arb_data,
    input  logic                          in_arb_finish,

    output logic [mmio_pkg::addr_w-1:0]   dcache_addr,
    output logic [mmio_pkg::data_w-1:0]   dcache_data,
    output logic [mmio_pkg::mask_w-1:0]   dcache_mask,
    output logic                          dcache_fence,
    output logic                          dcache_we,
    output logic                          dcache_re,
    input  logic [mmio_pkg::data_w-1:0]   in_dcache_data,
    input  logic                          in_dcache_finish
);

    logic                          path_finish;
    logic [mmio_pkg::data_w-1:0]   path_data;
    logic                          path_uncache;
    logic                          path_we;

    // Decode to issue link.
    mem_req_if u_req_if (
        .clk   (clk),
        .rst_n (rst_n)
    );

    // Fence goes straight to the cache.
    assign dcache_fence = fence_in;

    req_decode u_req_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .core_addr    (core_addr),
        .core_data    (core_data),
        .core_mask    (core_mask),
        .core_we_type (core_we_type),
        .core_we      (core_we),
        .core_re_type (core_re_type),
        .core_re      (core_re),
        .mmio_sign    (mmio_sign),
        .req          (u_req_if.producer)
    );

    path_issue u_path_issue (
        .req              (u_req_if.consumer),
        .dcache_addr      (dcache_addr),
        .dcache_data      (dcache_data),
        .dcache_mask      (dcache_mask),
        .dcache_we        (dcache_we),
        .dcache_re        (dcache_re),
        .in_dcache_data   (in_dcache_data),
        .in_dcache_finish (in_dcache_finish),
        .arb_addr         (arb_addr),
        .arb_data         (arb_data),
        .arb_mask         (arb_mask),
        .arb_we           (arb_we),
        .arb_re           (arb_re),
        .arb_size_data    (arb_size_data),
        .in_arb_data      (in_arb_data),
        .in_arb_finish    (in_arb_finish),
        .path_finish      (path_finish),
        .path_data        (path_data),
        .path_uncache     (path_uncache),
        .path_we          (path_we)
    );

    resp_merge u_resp_merge (
        .clk            (clk),
        .rst_n          (rst_n),
        .path_finish    (path_finish),
        .path_data      (path_data),
        .path_uncache   (path_uncache),
        .path_we        (path_we),
        .in_core_data   (in_core_data),
        .in_core_finish (in_core_finish)
    );

endmodule

/* list.f */
design/mmio_pkg.sv
design/mem_req_if.sv
design/req_decode.sv
design/path_issue.sv
design/resp_merge.sv
design/uncache_mmio.sv
verif/tb_clock.sv
verif/tb_responders.sv
verif/tb_uncache_mmio.sv

/* run_sim.sh */
#!/bin/sh
# Build the uncache_mmio testbench with Verilator and run it.
# The exit status is the simulator's: non-zero on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_uncache_mmio \
    -f list.f \
    --Mdir obj_dir -o tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

/* verif/tb_clock.sv */
module tb_clock (
    output logic clk,
    output logic rst_n
);

    // Free running clock, 10 units per period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset is held low over the first four rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* verif/tb_responders.sv */
module tb_responders (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          dcache_re,
    input  logic                          dcache_we,
    input  logic                          arb_re,
    input  logic                          arb_we,
    input  logic [mmio_pkg::data_w-1:0]   resp_data,
    output logic [mmio_pkg::data_w-1:0]   in_dcache_data,
    output logic                          in_dcache_finish,
    output logic [mmio_pkg::data_w-1:0]   in_arb_data,
    output logic                          in_arb_finish,
    output int                            dc_episodes,
    output int                            dc_cycles,
    output int                            arb_episodes,
    output int                            arb_cycles
);

    logic dc_on;
    logic arb_on;
    logic dc_was_on;
    logic arb_was_on;
    int   dc_left;
    int   arb_left;
    bit   seeded;

    assign dc_on  = dcache_re | dcache_we;
    assign arb_on = arb_re | arb_we;

    // Quiet ports before the first clock edge.
    initial begin
        in_dcache_data   = '0;
        in_dcache_finish = 1'b0;
        in_arb_data      = '0;
        in_arb_finish    = 1'b0;
        dc_left          = -1;
        arb_left         = -1;
    end

    // Both ports share one process, so one seed covers every draw.
    always @(posedge clk) begin
        if (!seeded) begin
            seeded = 1'b1;
            void'($urandom(87708));
        end
        if (!rst_n) begin
            in_dcache_finish <= 1'b0;
            in_arb_finish    <= 1'b0;
            in_dcache_data   <= '0;
            in_arb_data      <= '0;
            dc_was_on        <= 1'b0;
            arb_was_on       <= 1'b0;
            dc_episodes      <= 0;
            dc_cycles        <= 0;
            arb_episodes     <= 0;
            arb_cycles       <= 0;
            dc_left = -1;
            arb_left = -1;
        end else begin
            dc_was_on  <= dc_on;
            arb_was_on <= arb_on;
            // A rising strobe starts a new episode.
            if (dc_on && !dc_was_on) dc_episodes <= dc_episodes + 1;
            if (arb_on && !arb_was_on) arb_episodes <= arb_episodes + 1;
            if (dc_on) dc_cycles <= dc_cycles + 1;
            if (arb_on) arb_cycles <= arb_cycles + 1;
            // Finish lasts one cycle.
            in_dcache_finish <= 1'b0;
            in_arb_finish    <= 1'b0;
            // Latency of 0 to 5 cycles, drawn once per episode.
            if (dc_on) begin
                if (dc_left < 0) dc_left = int'($urandom % 6);
                if (dc_left == 0) begin
                    in_dcache_finish <= 1'b1;
                    in_dcache_data   <= resp_data;
                end
                dc_left = dc_left - 1;
            end
            if (arb_on) begin
                if (arb_left < 0) arb_left = int'($urandom % 6);
                if (arb_left == 0) begin
                    in_arb_finish <= 1'b1;
                    in_arb_data   <= resp_data;
                end
                arb_left = arb_left - 1;
            end
        end
    end

endmodule

/* verif/tb_uncache_mmio.sv */
module tb_uncache_mmio;

    logic                          clk;
    logic                          rst_n;
    logic [2:0]                    mmio_sign;
    logic [mmio_pkg::addr_w-1:0]   core_addr;
    logic [mmio_pkg::data_w-1:0]   core_data;
    logic [mmio_pkg::mask_w-1:0]   core_mask;
    logic                          fence_in;
    logic [2:0]                    core_we_type;
    logic                          core_we;
    logic [2:0]                    core_re_type;
    logic                          core_re;
    logic [mmio_pkg::data_w-1:0]   in_core_data;
    logic                          in_core_finish;
    logic [mmio_pkg::addr_w-1:0]   arb_addr;
    logic [mmio_pkg::data_w-1:0]   arb_data;
    logic [mmio_pkg::mask_w-1:0]   arb_mask;
    logic                          arb_we;
    logic                          arb_re;
    logic [2:0]                    arb_size_data;
    logic [mmio_pkg::data_w-1:0]   in_arb_data;
    logic                          in_arb_finish;
    logic [mmio_pkg::addr_w-1:0]   dcache_addr;
    logic [mmio_pkg::data_w-1:0]   dcache_data;
    logic [mmio_pkg::mask_w-1:0]   dcache_mask;
    logic                          dcache_fence;
    logic                          dcache_we;
    logic                          dcache_re;
    logic [mmio_pkg::data_w-1:0]   in_dcache_data;
    logic                          in_dcache_finish;
    logic [mmio_pkg::data_w-1:0]   resp_data;
    int                            dc_episodes;
    int                            dc_cycles;
    int                            arb_episodes;
    int                            arb_cycles;

    // Current line of test data.
    string                         test_name;
    string                         line;
    string                         op;
    string                         port;
    logic [2:0]                    typ;
    logic [2:0]                    exp_size;
    logic [2:0]                    exp_sign;
    logic [mmio_pkg::addr_w-1:0]   addr;
    logic [mmio_pkg::addr_w-1:0]   exp_bus_addr;
    logic [mmio_pkg::data_w-1:0]   data;
    logic [mmio_pkg::data_w-1:0]   resp;
    logic [mmio_pkg::data_w-1:0]   exp_core_data;
    logic [mmio_pkg::mask_w-1:0]   mask;
    logic                          is_wr;
    logic                          to_arb;
    int                            clint_flag;
    int                            fd;
    int                            fields;
    int                            waited;
    int                            n_tests;

    tb_clock u_clock (.*);
    uncache_mmio u_uncache_mmio (.*);
    tb_responders u_responders (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic compare_value(input string what, input logic [63:0] exp,
                                 input logic [63:0] got);
        assert (got == exp) else
            stop_run($sformatf("FAIL %s %s expected %h actual %h", test_name, what, exp, got));
    endtask

    // Fence has no state, it only passes through to the cache.
    task automatic check_fence();
        test_name = "fence";
        @(posedge clk);
        #1;
        fence_in = 1'b1;
        @(negedge clk);
        compare_value("dcache_fence high", 64'd1, 64'(dcache_fence));
        @(posedge clk);
        #1;
        fence_in = 1'b0;
        @(negedge clk);
        compare_value("dcache_fence low", 64'd0, 64'(dcache_fence));
    endtask

    // Mid-cycle look at both downstream ports.
    task automatic watch_ports();
        logic dc_on;
        logic arb_on;
        dc_on  = dcache_re | dcache_we;
        arb_on = arb_re | arb_we;
        assert (to_arb ? !dc_on : !arb_on) else
            stop_run($sformatf("%s: a strobe is active on the wrong port", test_name));
        if (dc_on || arb_on) begin
            compare_value("mmio_sign held", 64'(exp_sign), 64'(mmio_sign));
        end
        // Cache side sees the raw request.
        if (dc_on) begin
            compare_value("dcache_we", 64'(is_wr), 64'(dcache_we));
            compare_value("dcache_addr", addr, dcache_addr);
            compare_value("dcache_data", data, dcache_data);
            compare_value("dcache_mask", 64'(mask), 64'(dcache_mask));
        end
        // Device side sees the aligned address and the size code.
        if (arb_on) begin
            compare_value("arb_we", 64'(is_wr), 64'(arb_we));
            compare_value("arb_addr", exp_bus_addr, arb_addr);
            compare_value("arb_size_data", 64'(exp_size), 64'(arb_size_data));
            compare_value("arb_mask", 64'(mask), 64'(arb_mask));
            if (is_wr) compare_value("arb_data", data, arb_data);
        end
    endtask

    // One full access, from idle to release.
    task automatic run_access();
        int dc_base;
        int arb_base;
        int cyc_base;
        is_wr    = (op == "wr");
        to_arb   = (port == "arb");
        exp_sign = (clint_flag != 0) ? mmio_pkg::sign_clint : mmio_pkg::sign_other;
        assert (is_wr || op == "rd") else stop_run($sformatf("%s: unknown op %s", test_name, op));
        assert (to_arb || port == "dc") else
            stop_run($sformatf("%s: unknown port %s", test_name, port));
        @(negedge clk);
        compare_value("idle mmio_sign", 64'(mmio_pkg::sign_other), 64'(mmio_sign));
        compare_value("idle in_core_finish", 64'd0, 64'(in_core_finish));
        assert (!(dcache_re || dcache_we || arb_re || arb_we)) else
            stop_run($sformatf("%s: strobe active before the request", test_name));
        dc_base  = dc_episodes;
        arb_base = arb_episodes;
        cyc_base = dc_cycles + arb_cycles;
        @(posedge clk);
        #1;
        // The unused type field carries the inverse code.
        core_addr    = addr;
        core_data    = data;
        core_mask    = mask;
        core_we      = is_wr;
        core_re      = !is_wr;
        core_we_type = is_wr ? typ : ~typ;
        core_re_type = is_wr ? ~typ : typ;
        resp_data    = resp;
        waited = 0;
        do begin
            @(negedge clk);
            watch_ports();
            waited++;
        end while (!in_core_finish && waited < 100);
        assert (in_core_finish) else
            stop_run($sformatf("%s: no in_core_finish within 100 cycles", test_name));
        // Reads take the responder word, writes keep the old one.
        if (!is_wr) exp_core_data = resp;
        compare_value("in_core_data", exp_core_data, in_core_data);
        compare_value("mmio_sign at finish", 64'(exp_sign), 64'(mmio_sign));
        @(posedge clk);
        #1;
        core_we = 1'b0;
        core_re = 1'b0;
        @(negedge clk);
        compare_value("in_core_finish pulse", 64'd0, 64'(in_core_finish));
        compare_value("mmio_sign after finish", 64'(mmio_pkg::sign_other), 64'(mmio_sign));
        assert (!(dcache_re || dcache_we || arb_re || arb_we)) else
            stop_run($sformatf("%s: request issued again after finish", test_name));
        compare_value("dcache episodes", 64'(to_arb ? dc_base : dc_base + 1), 64'(dc_episodes));
        compare_value("arb episodes", 64'(to_arb ? arb_base + 1 : arb_base), 64'(arb_episodes));
        // The access takes its strobe cycles plus three fixed cycles.
        compare_value("access latency", 64'(dc_cycles + arb_cycles - cyc_base + 3), 64'(waited));
    endtask

    initial begin
        core_addr     = '0;
        core_data     = '0;
        core_mask     = '0;
        fence_in      = 1'b0;
        core_we_type  = 3'd0;
        core_we       = 1'b0;
        core_re_type  = 3'd0;
        core_re       = 1'b0;
        resp_data     = '0;
        exp_core_data = '0;
        n_tests       = 0;
        test_name     = "reset";
        waited = 0;
        while (!rst_n && waited < 100) begin
            @(posedge clk);
            waited++;
        end
        assert (rst_n) else stop_run("reset was never released");
        check_fence();
        fd = $fopen("verif/testdata_access.txt", "r");
        assert (fd != 0) else stop_run("cannot open verif/testdata_access.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %s %h %h %h %h %h %s %h %h %h", test_name, op, typ,
                             addr, data, mask, resp, port, exp_bus_addr, exp_size, clint_flag);
            assert (fields == 11) else stop_run($sformatf("malformed test data line: %s", line));
            run_access();
            n_tests++;
        end
        $fclose(fd);
        assert (n_tests > 0) else stop_run("the test data holds no accesses");
        $display("All tests passed");
        $finish;
    end

endmodule

/* verif/testdata_access.txt */
# name op type addr data mask resp port bus_addr size clint
# op is rd or wr, type and size are hex codes, port is dc or arb, clint 1 flags a CLINT access
dc_rd_dword rd 4 80001008 0 ff 1122334455667788 dc 80001008 3 0
dc_wr_word wr 2 80002004 00000000cafef00d 0f 000000000000dead dc 80002004 2 0
dc_rd_byte rd 0 80000013 0 01 00000000000000a5 dc 80000013 0 0
dc_rd_oddtype rd 3 80000021 0 01 5a5a5a5a5a5a5a5a dc 80000021 0 0
uart_wr_byte wr 0 10000005 0000000000000041 20 000000000000beef arb 10000005 0 0
uart_rd_half rd 1 10000007 0 c0 0000000000001234 arb 10000006 1 0
uart_rd_end rd 0 10000fff 0 80 00000000000000c3 arb 10000fff 0 0
spictrl_wr_word wr 2 10001016 00000000deadbeef f0 0000000000000001 arb 10001014 2 0
spictrl_rd_dword rd 4 1000100f 0 ff 0123456789abcdef arb 10001008 3 0
spi_rd_word rd 2 30000123 0 0f 00000000a5a5f00f arb 30000120 2 0
spi_wr_dword wr 4 3ffffffd 8877665544332211 ff 0000000000000002 arb 3ffffff8 3 0
spi_rd_badtype rd 7 30000003 0 08 0000000000000077 arb 30000003 0 0
clint_rd_dword rd 4 0200bff8 0 ff 000000000000c350 arb 0200bff8 3 1
clint_wr_word wr 2 02004006 0000000000000064 0f 0000000000000003 arb 02004004 2 1
below_uart_rd rd 4 0ffffff8 0 ff 0f0f0f0f0f0f0f0f dc 0ffffff8 3 0
after_spictrl_wr wr 1 10002000 000000000000abcd 03 0000000000000004 dc 10002000 1 0
above_clint_rd rd 2 02010000 0 0f 00000000feedface dc 02010000 2 0
dc_rd_last rd 4 80003000 0 ff fedcba9876543210 dc 80003000 3 0
